// File: include/arb_settings.svh
`ifndef ARB_SETTINGS_SVH
`define ARB_SETTINGS_SVH

// client channels sharing the controller
`define ARB_NUM_CH      5

// one burst beat on the controller data bus
`define ARB_DATA_WIDTH  128

// controller byte address
`define ARB_ADDR_SIZE   28

// burst length in beats
`define ARB_LEN_WIDTH   10

`endif

// File: hdl/arb_pkg.sv
`include "arb_settings.svh"

package arb_pkg;

    typedef logic [`ARB_DATA_WIDTH-1:0] data_t;

    typedef logic [`ARB_ADDR_SIZE-1:0] addr_t;

    typedef logic [`ARB_LEN_WIDTH-1:0] len_t;

    // one bit per channel, zero when nobody owns the port
    typedef logic [`ARB_NUM_CH-1:0] grant_t;

    typedef logic [$clog2(`ARB_NUM_CH)-1:0] ch_idx_t;

    // idle only right after reset
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_PROBE,
        ARB_BUSY
    } arb_state_e;

endpackage

// File: hdl/rr_burst_scheduler.sv
`timescale 1ns/100ps
`include "arb_settings.svh"

module rr_burst_scheduler (
    input  logic                    ddr_clk,
    input  logic                    ddr_rstn,

    input  logic [`ARB_NUM_CH-1:0]  req,
    input  arb_pkg::addr_t          addr [`ARB_NUM_CH],
    input  arb_pkg::len_t           len  [`ARB_NUM_CH],
    input  logic                    finish,

    output logic                    burst_req,
    output arb_pkg::addr_t          burst_addr,
    output arb_pkg::len_t           burst_len,
    output arb_pkg::grant_t         grant
);

    import arb_pkg::*;

    localparam ch_idx_t last_ch = ch_idx_t'(`ARB_NUM_CH - 1);

    arb_state_e state;
    ch_idx_t    ptr;
    ch_idx_t    ptr_nxt;
    logic       probe_hit;

    // cyclic pointer, wraps after the last channel
    assign ptr_nxt = (ptr == last_ch) ? '0 : ptr + 1'b1;

    // pointed channel is asking while we look at it
    assign probe_hit = (state == ARB_PROBE) && req[ptr];

    always_ff @(posedge ddr_clk or negedge ddr_rstn) begin
        if (!ddr_rstn) begin
            state     <= ARB_IDLE;
            ptr       <= '0;
            burst_req <= 1'b0;
            grant     <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    state <= ARB_PROBE;
                    ptr   <= '0;
                end

                // one channel per cycle
                ARB_PROBE: begin
                    if (probe_hit) begin
                        state     <= ARB_BUSY;
                        burst_req <= 1'b1;
                        grant     <= grant_t'(1'b1) << ptr;
                    end else begin
                        ptr <= ptr_nxt;
                    end
                end

                // hold request and grant until the controller is done
                ARB_BUSY: begin
                    if (finish) begin
                        state     <= ARB_PROBE;
                        burst_req <= 1'b0;
                        grant     <= '0;
                        ptr       <= ptr_nxt;
                    end
                end

                default: begin
                    state     <= ARB_IDLE;
                    burst_req <= 1'b0;
                    grant     <= '0;
                end
            endcase
        end
    end

    // burst descriptor, taken from the winner
    always_ff @(posedge ddr_clk) begin
        if (probe_hit) begin
            burst_addr <= addr[ptr];
            burst_len  <= len[ptr];
        end
    end

endmodule

// File: hdl/wr_port_steer.sv
`timescale 1ns/100ps
`include "arb_settings.svh"

module wr_port_steer (
    input  logic                    ddr_clk,
    input  logic                    ddr_rstn,

    input  arb_pkg::grant_t         grant,
    input  arb_pkg::data_t          ch_data [`ARB_NUM_CH],
    input  logic                    data_req,
    input  logic                    finish,

    output arb_pkg::data_t          burst_data,
    output logic [`ARB_NUM_CH-1:0]  ch_valid,
    output logic [`ARB_NUM_CH-1:0]  ch_finish
);

    import arb_pkg::*;

    grant_t grant_q;

    // grant seen by the data path, one cycle behind the scheduler
    always_ff @(posedge ddr_clk or negedge ddr_rstn) begin
        if (!ddr_rstn) begin
            grant_q <= '0;
        end else begin
            grant_q <= grant;
        end
    end

    // one-hot select, zero when no owner
    always_comb begin
        burst_data = '0;
        for (int i = 0; i < `ARB_NUM_CH; i++) begin
            if (grant_q[i]) begin
                burst_data = ch_data[i];
            end
        end
    end

    // beat strobe and finish only reach the owner
    assign ch_valid  = grant_q & {`ARB_NUM_CH{data_req}};
    assign ch_finish = grant_q & {`ARB_NUM_CH{finish}};

endmodule

// File: hdl/rd_port_steer.sv
`timescale 1ns/100ps
`include "arb_settings.svh"

module rd_port_steer (
    input  logic                    ddr_clk,
    input  logic                    ddr_rstn,

    input  arb_pkg::grant_t         grant,
    input  arb_pkg::data_t          burst_data,
    input  logic                    data_valid,
    input  logic                    finish,

    output arb_pkg::data_t          ch_data [`ARB_NUM_CH],
    output logic [`ARB_NUM_CH-1:0]  ch_valid,
    output logic [`ARB_NUM_CH-1:0]  ch_finish
);

    import arb_pkg::*;

    grant_t grant_q;

    always_ff @(posedge ddr_clk or negedge ddr_rstn) begin
        if (!ddr_rstn) begin
            grant_q <= '0;
        end else begin
            grant_q <= grant;
        end
    end

    // every client sees the bus, valid tells it whose beat it is
    for (genvar g = 0; g < `ARB_NUM_CH; g++) begin : g_fanout
        assign ch_data[g] = burst_data;
    end

    assign ch_valid  = grant_q & {`ARB_NUM_CH{data_valid}};
    assign ch_finish = grant_q & {`ARB_NUM_CH{finish}};

endmodule

// File: hdl/ddr_burst_arbiter.sv
`timescale 1ns/100ps
`include "arb_settings.svh"

module ddr_burst_arbiter (
    input  logic                    ddr_clk,
    input  logic                    ddr_rstn,

    // write clients
    input  arb_pkg::data_t          wr_ch_data   [`ARB_NUM_CH],
    input  arb_pkg::addr_t          wr_ch_addr   [`ARB_NUM_CH],
    input  arb_pkg::len_t           wr_ch_len    [`ARB_NUM_CH],
    input  logic [`ARB_NUM_CH-1:0]  wr_ch_req,
    output logic [`ARB_NUM_CH-1:0]  wr_ch_valid,
    output logic [`ARB_NUM_CH-1:0]  wr_ch_finish,

    // read clients
    output arb_pkg::data_t          rd_ch_data   [`ARB_NUM_CH],
    input  arb_pkg::addr_t          rd_ch_addr   [`ARB_NUM_CH],
    input  arb_pkg::len_t           rd_ch_len    [`ARB_NUM_CH],
    input  logic [`ARB_NUM_CH-1:0]  rd_ch_req,
    output logic [`ARB_NUM_CH-1:0]  rd_ch_valid,
    output logic [`ARB_NUM_CH-1:0]  rd_ch_finish,

    // controller write port
    output arb_pkg::data_t          wr_burst_data,
    output arb_pkg::addr_t          wr_burst_addr,
    output arb_pkg::len_t           wr_burst_len,
    output logic                    wr_burst_req,
    input  logic                    wr_burst_data_req,
    input  logic                    wr_burst_finish,

    // controller read port
    input  arb_pkg::data_t          rd_burst_data,
    output arb_pkg::addr_t          rd_burst_addr,
    output arb_pkg::len_t           rd_burst_len,
    output logic                    rd_burst_req,
    input  logic                    rd_burst_data_valid,
    input  logic                    rd_burst_finish
);

    import arb_pkg::*;

    grant_t wr_grant;
    grant_t rd_grant;

    // write direction
    rr_burst_scheduler u_wr_sched (
        .ddr_clk    (ddr_clk),
        .ddr_rstn   (ddr_rstn),
        .req        (wr_ch_req),
        .addr       (wr_ch_addr),
        .len        (wr_ch_len),
        .finish     (wr_burst_finish),
        .burst_req  (wr_burst_req),
        .burst_addr (wr_burst_addr),
        .burst_len  (wr_burst_len),
        .grant      (wr_grant)
    );

    wr_port_steer u_wr_steer (
        .ddr_clk    (ddr_clk),
        .ddr_rstn   (ddr_rstn),
        .grant      (wr_grant),
        .ch_data    (wr_ch_data),
        .data_req   (wr_burst_data_req),
        .finish     (wr_burst_finish),
        .burst_data (wr_burst_data),
        .ch_valid   (wr_ch_valid),
        .ch_finish  (wr_ch_finish)
    );

    // read direction, scheduled on its own
    rr_burst_scheduler u_rd_sched (
        .ddr_clk    (ddr_clk),
        .ddr_rstn   (ddr_rstn),
        .req        (rd_ch_req),
        .addr       (rd_ch_addr),
        .len        (rd_ch_len),
        .finish     (rd_burst_finish),
        .burst_req  (rd_burst_req),
        .burst_addr (rd_burst_addr),
        .burst_len  (rd_burst_len),
        .grant      (rd_grant)
    );

    rd_port_steer u_rd_steer (
        .ddr_clk    (ddr_clk),
        .ddr_rstn   (ddr_rstn),
        .grant      (rd_grant),
        .burst_data (rd_burst_data),
        .data_valid (rd_burst_data_valid),
        .finish     (rd_burst_finish),
        .ch_data    (rd_ch_data),
        .ch_valid   (rd_ch_valid),
        .ch_finish  (rd_ch_finish)
    );

endmodule

// File: tb/arb_checker.sv
`timescale 1ns/100ps
`include "arb_settings.svh"

module arb_checker (
    input logic                    ddr_clk,
    input logic                    ddr_rstn,
    input arb_pkg::grant_t         wr_grant,
    input arb_pkg::grant_t         rd_grant,
    input logic [`ARB_NUM_CH-1:0]  wr_ch_valid,
    input logic [`ARB_NUM_CH-1:0]  rd_ch_valid,
    input logic [`ARB_NUM_CH-1:0]  wr_ch_finish,
    input logic [`ARB_NUM_CH-1:0]  rd_ch_finish,
    input logic                    wr_burst_finish,
    input logic                    rd_burst_finish,
    input logic                    wr_burst_req,
    input logic                    rd_burst_req
);

    a_wr_grant_onehot: assert property (@(posedge ddr_clk) disable iff (!ddr_rstn)
        $onehot0(wr_grant)) else $error("write grant has more than one bit set");
    a_rd_grant_onehot: assert property (@(posedge ddr_clk) disable iff (!ddr_rstn)
        $onehot0(rd_grant)) else $error("read grant has more than one bit set");

    a_wr_valid_single: assert property (@(posedge ddr_clk) disable iff (!ddr_rstn)
        $onehot0(wr_ch_valid)) else $error("several write channels strobed at once");
    a_rd_valid_single: assert property (@(posedge ddr_clk) disable iff (!ddr_rstn)
        $onehot0(rd_ch_valid)) else $error("several read channels strobed at once");

    // channel finish only mirrors the controller pulse
    a_wr_finish_src: assert property (@(posedge ddr_clk) disable iff (!ddr_rstn)
        !wr_burst_finish |-> wr_ch_finish == '0) else $error("write finish without controller");
    a_rd_finish_src: assert property (@(posedge ddr_clk) disable iff (!ddr_rstn)
        !rd_burst_finish |-> rd_ch_finish == '0) else $error("read finish without controller");

    a_wr_req_held: assert property (@(posedge ddr_clk) disable iff (!ddr_rstn)
        wr_grant != '0 |-> wr_burst_req) else $error("write grant without request");
    a_rd_req_held: assert property (@(posedge ddr_clk) disable iff (!ddr_rstn)
        rd_grant != '0 |-> rd_burst_req) else $error("read grant without request");

endmodule

bind ddr_burst_arbiter arb_checker u_checker (
    .ddr_clk         (ddr_clk),
    .ddr_rstn        (ddr_rstn),
    .wr_grant        (wr_grant),
    .rd_grant        (rd_grant),
    .wr_ch_valid     (wr_ch_valid),
    .rd_ch_valid     (rd_ch_valid),
    .wr_ch_finish    (wr_ch_finish),
    .rd_ch_finish    (rd_ch_finish),
    .wr_burst_finish (wr_burst_finish),
    .rd_burst_finish (rd_burst_finish),
    .wr_burst_req    (wr_burst_req),
    .rd_burst_req    (rd_burst_req)
);

// File: include/arb_tb_rules.svh
`ifndef ARB_TB_RULES_SVH
`define ARB_TB_RULES_SVH

// bursts each client issues per direction
`define TB_BURSTS_PER_CLIENT  6

// longest burst a client asks for, in beats
`define TB_MAX_LEN            8

`endif

// File: tb/tb_ddr_burst_arbiter.sv
`timescale 1ns/100ps
`include "arb_settings.svh"
`include "arb_tb_rules.svh"

// one client holding a level request until its finish pulse
module burst_client #(
    parameter int SEED = 0
) (
    input  logic           ddr_clk,
    input  logic           ddr_rstn,
    input  logic           valid,
    input  logic           finish,
    output logic           req,
    output arb_pkg::len_t  len,
    output int             cnt,
    output int             beat,
    output logic           done
);

    integer seed;
    int     gap;
    logic   v;
    logic   f;

    initial begin
        seed = SEED;
        req  = 1'b0;
        len  = 1;
        cnt  = 0;
        beat = 0;
        done = 1'b0;
        wait (ddr_rstn === 1'b1);
        for (int b = 0; b < `TB_BURSTS_PER_CLIENT; b++) begin
            gap = $unsigned($random(seed)) % 6;
            repeat (gap + 1) @(negedge ddr_clk);
            cnt  = b;
            beat = 0;
            len  = arb_pkg::len_t'(1 + $unsigned($random(seed)) % `TB_MAX_LEN);
            req  = 1'b1;
            f    = 1'b0;
            while (!f) begin
                @(posedge ddr_clk);
                v = valid;
                f = finish;
                @(negedge ddr_clk);
                if (v) begin
                    beat++;
                end
            end
            req = 1'b0;
        end
        done = 1'b1;
    end

endmodule

module tb_ddr_burst_arbiter;

    import arb_pkg::*;

    localparam int NCH = `ARB_NUM_CH;
    localparam int CH_MSB = `ARB_ADDR_SIZE - 1;
    localparam int SEED = 32'hb732_b94d;
    localparam int TOTAL_BURSTS = 2 * NCH * `TB_BURSTS_PER_CLIENT;
    // client gap, full probe round, spaced beats and finish
    localparam int MAX_BURST_CYCLES = 6 + NCH + 3 * `TB_MAX_LEN + 4;
    localparam int TIMEOUT_NS = TOTAL_BURSTS * MAX_BURST_CYCLES * 4 + 400;

    logic ddr_clk;
    logic ddr_rstn;
    integer seed = SEED;

    data_t             wr_ch_data [NCH];
    addr_t             wr_ch_addr [NCH];
    len_t              wr_ch_len  [NCH];
    wire  [NCH-1:0]    wr_ch_req;
    logic [NCH-1:0]    wr_ch_valid;
    logic [NCH-1:0]    wr_ch_finish;
    data_t             rd_ch_data [NCH];
    addr_t             rd_ch_addr [NCH];
    len_t              rd_ch_len  [NCH];
    wire  [NCH-1:0]    rd_ch_req;
    logic [NCH-1:0]    rd_ch_valid;
    logic [NCH-1:0]    rd_ch_finish;
    data_t             wr_burst_data;
    addr_t             wr_burst_addr;
    len_t              wr_burst_len;
    logic              wr_burst_req;
    logic              wr_burst_data_req;
    logic              wr_burst_finish;
    data_t             rd_burst_data;
    addr_t             rd_burst_addr;
    len_t              rd_burst_len;
    logic              rd_burst_req;
    logic              rd_burst_data_valid;
    logic              rd_burst_finish;
    wire  [NCH-1:0]    wr_done;
    wire  [NCH-1:0]    rd_done;

    // client state per direction with 0 for write and 1 for read
    int    cl_cnt  [2][NCH];
    int    cl_beat [2][NCH];
    len_t  cl_len  [2][NCH];

    // scoreboard
    int     errs [3];
    int     n_bursts [2];
    int     start [2];
    int     served [2];
    int     beats [2];
    logic   breq_q [2];
    logic   fin_q [2];
    grant_t held [2];

    function automatic data_t beat_data(input int ch, input int cnt, input int beat,
                                        input bit dir);
        logic [47:0] tag;
        tag = {ch[7:0], 7'd0, dir, cnt[15:0], beat[15:0]};
        return data_t'({tag, 80'h5a5a_0f0f_c3c3_9696_a5a5});
    endfunction

    // channel in the top bits, then direction, then burst count
    function automatic addr_t make_addr(input int ch, input bit dir, input int cnt);
        return addr_t'({ch[2:0], dir, cnt[7:0], 16'h0000});
    endfunction

    ddr_burst_arbiter DUT (.*);

    for (genvar c = 0; c < NCH; c++) begin : g_ch
        burst_client #(.SEED(SEED + c)) u_wr_client (
            .ddr_clk (ddr_clk), .ddr_rstn (ddr_rstn),
            .valid (wr_ch_valid[c]), .finish (wr_ch_finish[c]),
            .req (wr_ch_req[c]), .len (cl_len[0][c]), .cnt (cl_cnt[0][c]),
            .beat (cl_beat[0][c]), .done (wr_done[c])
        );
        burst_client #(.SEED(SEED + 16 + c)) u_rd_client (
            .ddr_clk (ddr_clk), .ddr_rstn (ddr_rstn),
            .valid (rd_ch_valid[c]), .finish (rd_ch_finish[c]),
            .req (rd_ch_req[c]), .len (cl_len[1][c]), .cnt (cl_cnt[1][c]),
            .beat (cl_beat[1][c]), .done (rd_done[c])
        );
        assign wr_ch_len[c]  = cl_len[0][c];
        assign rd_ch_len[c]  = cl_len[1][c];
        assign wr_ch_addr[c] = make_addr(c, 1'b0, cl_cnt[0][c]);
        assign rd_ch_addr[c] = make_addr(c, 1'b1, cl_cnt[1][c]);
        assign wr_ch_data[c] = beat_data(c, cl_cnt[0][c], cl_beat[0][c], 1'b0);
    end

    initial ddr_clk = 1'b0;
    always #2 ddr_clk = ~ddr_clk;

    task automatic check_data(input int t, input string name, input data_t got,
                              input data_t exp);
        if (got !== exp) begin
            errs[t]++;
            $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input int t, input string name, input addr_t got,
                              input addr_t exp);
        if (got !== exp) begin
            errs[t]++;
            $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_len(input int t, input string name, input len_t got, input len_t exp);
        if (got !== exp) begin
            errs[t]++;
            $display("mismatch at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_grant(input int t, input string name, input grant_t got,
                               input grant_t exp);
        if (got !== exp) begin
            errs[t]++;
            $display("mismatch at %0d ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_fault(input int t, input string msg);
        errs[t]++;
        $display("error at %0d ns: %s", $time, msg);
    endtask

    task automatic track_dir(input int d, input logic breq, input addr_t baddr,
                             input len_t blen, input grant_t grant, input grant_t req,
                             input logic strobe, input grant_t valid, input logic fin,
                             input grant_t ch_fin, input data_t data);
        int s;
        int c;
        string tag;
        tag = d ? "rd" : "wr";
        if (fin_q[d] && breq) begin
            report_fault(d + 1, {tag, " controller request still high after finish"});
        end
        if (breq && !breq_q[d]) begin
            s = int'(baddr[CH_MSB -: 3]);
            n_bursts[d]++;
            if (s >= NCH) begin
                report_fault(d + 1, {tag, " burst address names no channel"});
            end else begin
                check_grant(d + 1, {tag, "_grant"}, grant, grant_t'(1) << s);
                check_addr(d + 1, {tag, "_burst_addr"}, baddr, make_addr(s, d[0], cl_cnt[d][s]));
                check_len(d + 1, {tag, "_burst_len"}, blen, cl_len[d][s]);
                if (!req[s]) begin
                    report_fault(d + 1, $sformatf("%s channel %0d served without request", tag, s));
                end
                c = start[d];
                while (c != s) begin
                    if (held[d][c]) begin
                        report_fault(d + 1, $sformatf("%s channel %0d skipped", tag, c));
                    end
                    c = (c + 1) % NCH;
                end
                served[d] = s;
                beats[d]  = 0;
            end
        end
        if (strobe) begin
            if (!breq) begin
                report_fault(d + 1, {tag, " data strobe outside a burst"});
            end
            check_grant(d + 1, {tag, "_ch_valid"}, valid, grant_t'(1) << served[d]);
            check_data(d + 1, {tag, "_data"}, data,
                       beat_data(served[d], cl_cnt[d][served[d]], beats[d], d[0]));
            beats[d]++;
        end
        if (fin) begin
            check_grant(d + 1, {tag, "_ch_finish"}, ch_fin, grant_t'(1) << served[d]);
            // beats the client itself counted from its valid strobe
            check_len(d + 1, {tag, "_beat_count"}, len_t'(cl_beat[d][served[d]]),
                      cl_len[d][served[d]]);
            start[d] = (served[d] + 1) % NCH;
            held[d]  = req;
        end else begin
            held[d] = held[d] & req;
        end
        breq_q[d] = breq;
        fin_q[d]  = fin;
    endtask

    always @(posedge ddr_clk) begin
        if (ddr_rstn) begin
            track_dir(0, wr_burst_req, wr_burst_addr, wr_burst_len, DUT.wr_grant, wr_ch_req,
                      wr_burst_data_req, wr_ch_valid, wr_burst_finish, wr_ch_finish,
                      wr_burst_data);
            track_dir(1, rd_burst_req, rd_burst_addr, rd_burst_len, DUT.rd_grant, rd_ch_req,
                      rd_burst_data_valid, rd_ch_valid, rd_burst_finish, rd_ch_finish,
                      rd_ch_data[served[1]]);
            if (rd_burst_data_valid) begin
                for (int c = 0; c < NCH; c++) begin
                    check_data(2, $sformatf("rd_ch_data[%0d]", c), rd_ch_data[c], rd_burst_data);
                end
            end
        end
    end

    // controller write side
    initial begin : wr_responder
        len_t n;
        int   gap;
        wr_burst_data_req = 1'b0;
        wr_burst_finish   = 1'b0;
        wait (ddr_rstn === 1'b1);
        forever begin
            @(negedge ddr_clk);
            if (wr_burst_req) begin
                n = wr_burst_len;
                for (int i = 0; i < int'(n); i++) begin
                    gap = $unsigned($random(seed)) % 3;
                    @(negedge ddr_clk);
                    wr_burst_data_req = 1'b0;
                    repeat (gap) @(negedge ddr_clk);
                    wr_burst_data_req = 1'b1;
                end
                @(negedge ddr_clk);
                wr_burst_data_req = 1'b0;
                wr_burst_finish   = 1'b1;
                @(negedge ddr_clk);
                wr_burst_finish = 1'b0;
            end
        end
    end

    // controller read side builds data from the address tag
    initial begin : rd_responder
        addr_t a;
        len_t  n;
        int    gap;
        rd_burst_data       = '0;
        rd_burst_data_valid = 1'b0;
        rd_burst_finish     = 1'b0;
        wait (ddr_rstn === 1'b1);
        forever begin
            @(negedge ddr_clk);
            if (rd_burst_req) begin
                a = rd_burst_addr;
                n = rd_burst_len;
                for (int i = 0; i < int'(n); i++) begin
                    gap = $unsigned($random(seed)) % 3;
                    @(negedge ddr_clk);
                    rd_burst_data_valid = 1'b0;
                    repeat (gap) @(negedge ddr_clk);
                    rd_burst_data = beat_data(int'(a[CH_MSB -: 3]), int'(a[CH_MSB-4 -: 8]),
                                              i, 1'b1);
                    rd_burst_data_valid = 1'b1;
                end
                @(negedge ddr_clk);
                rd_burst_data_valid = 1'b0;
                rd_burst_finish     = 1'b1;
                @(negedge ddr_clk);
                rd_burst_finish = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout: traffic did not complete within %0d ns", TIMEOUT_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : main
        errs     = '{0, 0, 0};
        n_bursts = '{0, 0};
        start    = '{0, 0};
        served   = '{0, 0};
        beats    = '{0, 0};
        breq_q   = '{1'b0, 1'b0};
        fin_q    = '{1'b0, 1'b0};
        held     = '{'1, '1};
        ddr_rstn = 1'b0;
        repeat (3) @(negedge ddr_clk);
        if (wr_burst_req || rd_burst_req) begin
            report_fault(0, "controller request high during reset");
        end
        check_grant(0, "wr_ch_valid", wr_ch_valid, '0);
        check_grant(0, "wr_ch_finish", wr_ch_finish, '0);
        check_grant(0, "rd_ch_valid", rd_ch_valid, '0);
        check_grant(0, "rd_ch_finish", rd_ch_finish, '0);
        @(negedge ddr_clk);
        ddr_rstn = 1'b1;
        $display("test reset_values: %0d errors", errs[0]);
        wait (&wr_done && &rd_done);
        repeat (4) @(negedge ddr_clk);
        for (int d = 0; d < 2; d++) begin
            if (n_bursts[d] != NCH * `TB_BURSTS_PER_CLIENT) begin
                report_fault(d + 1, $sformatf("%0d bursts seen, %0d issued", n_bursts[d],
                                              NCH * `TB_BURSTS_PER_CLIENT));
            end
        end
        $display("test write_bursts: %0d bursts, %0d errors", n_bursts[0], errs[1]);
        $display("test read_bursts: %0d bursts, %0d errors", n_bursts[1], errs[2]);
        $display("totals: %0d bursts, %0d errors", n_bursts[0] + n_bursts[1],
                 errs[0] + errs[1] + errs[2]);
        if (errs[0] + errs[1] + errs[2] == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
hdl/arb_pkg.sv
hdl/rr_burst_scheduler.sv
hdl/wr_port_steer.sv
hdl/rd_port_steer.sv
hdl/ddr_burst_arbiter.sv
tb/arb_checker.sv
tb/tb_ddr_burst_arbiter.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f vlog.f \
    --top-module tb_ddr_burst_arbiter -Mdir obj_dir -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log

grep -q "Simulation finished: FAIL" sim.log && { echo "test failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "no result in log"; exit 1; }
exit 0
